/* design/vector_unit_macros.svh */
`ifndef VECTOR_UNIT_MACROS_SVH
`define VECTOR_UNIT_MACROS_SVH

// Datapath word and Wishbone address widths
`define VU_DATA_W 32
`define VU_ADDR_W 5

// Register byte offsets on the Wishbone port
`define VU_REG_OPA    5'h00
`define VU_REG_OPB    5'h04
`define VU_REG_CTRL   5'h08
`define VU_REG_RESULT 5'h0C
`define VU_REG_STATUS 5'h10

`endif

/* design/vector_unit_pkg.sv */
package vector_unit_pkg;

    // Lane layout of a 32-bit word
    // Encodings 2 and 3 are reserved and decode as two 16-bit lanes
    typedef enum logic [1:0] {
        ESIZE_8  = 2'b00,
        ESIZE_16 = 2'b01
    } esize_t;

    // Host opcode in CTRL[3:0]
    // Shift opcodes follow the shifter micro-op order, add opcodes the
    // adder micro-op order, so the low bits select the micro-op directly
    typedef enum logic [3:0] {
        OP_VSRA       = 4'd0,
        OP_RND_VSRA   = 4'd1,
        OP_VSRL       = 4'd2,
        OP_RND_VSRL   = 4'd3,
        OP_VSLL       = 4'd4,
        OP_SAT_VSLL   = 4'd5,
        OP_VSATL_SMPR = 4'd6,
        OP_VSATL_RNDR = 4'd7,
        OP_VADD       = 4'd8,
        OP_VSUB       = 4'd9,
        OP_SAT_VADD   = 4'd10,
        OP_SAT_VSUB   = 4'd11
    } vunit_op_t;

    // Shifter micro-ops
    typedef enum logic [2:0] {
        VSRA, RND_VSRA, VSRL, RND_VSRL, VSLL, SAT_VSLL, VSATL_SMPR, VSATL_RNDR
    } vshift_uops_t;

    // Adder micro-ops
    typedef enum logic [1:0] {
        VADD, VSUB, SAT_VADD, SAT_VSUB
    } vadd_uops_t;

endpackage : vector_unit_pkg

/* design/vector_shift_unit.sv */
`timescale 1ns/1ps
`include "vector_unit_macros.svh"

module vector_shift_unit import vector_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  data_valid_i,
    input  logic [`VU_DATA_W-1:0] operand_i,
    input  logic [4:0]            shift_amt_i,
    input  esize_t                vector_length_i,
    input  vshift_uops_t          operation_i,
    output logic [`VU_DATA_W-1:0] result_o,
    output logic                  data_valid_o,
    output logic                  overflow_flag_o
);

    // What stage two does with the registered shift
    typedef enum logic [1:0] {
        MODE_PASS,
        MODE_ROUND,
        MODE_SAT
    } post_mode_t;

    // ----------------------------------------
    // Lane shifters of stage one
    // ----------------------------------------

    // Only the magnitude of the signed amount sets the distance
    logic [3:0] shift_mag;

    assign shift_mag = shift_amt_i[4] ? 4'(5'd0 - shift_amt_i) : shift_amt_i[3:0];

    logic [`VU_DATA_W-1:0] sll_res, sll_out, srl_res, sra_res;
    logic [3:0]            srl_last, sra_last, lane_sign;

    // Flags of a 16-bit lane sit on odd indices and even ones stay zero
    always_comb begin : lane_shifts
        sll_res   = '0;
        sll_out   = '0;
        srl_res   = '0;
        sra_res   = '0;
        srl_last  = '0;
        sra_last  = '0;
        lane_sign = '0;
        if (vector_length_i == ESIZE_8) begin
            for (int i = 0; i < 4; i++) begin
                {sll_out[8*i +: 8], sll_res[8*i +: 8]} =
                    {8'h00, operand_i[8*i +: 8]} << shift_mag[2:0];
                // Extra low bit catches the last bit shifted out
                {srl_res[8*i +: 8], srl_last[i]} =
                    {operand_i[8*i +: 8], 1'b0} >> shift_mag[2:0];
                {sra_res[8*i +: 8], sra_last[i]} =
                    $signed({operand_i[8*i +: 8], 1'b0}) >>> shift_mag[2:0];
                lane_sign[i] = operand_i[8*i+7];
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                {sll_out[16*i +: 16], sll_res[16*i +: 16]} =
                    {16'h0000, operand_i[16*i +: 16]} << shift_mag;
                {srl_res[16*i +: 16], srl_last[2*i+1]} =
                    {operand_i[16*i +: 16], 1'b0} >> shift_mag;
                {sra_res[16*i +: 16], sra_last[2*i+1]} =
                    $signed({operand_i[16*i +: 16], 1'b0}) >>> shift_mag;
                lane_sign[2*i+1] = operand_i[16*i+15];
            end
        end
    end : lane_shifts

    // Pick the shift and the treatment for stage two
    logic [`VU_DATA_W-1:0] shift_sel;
    logic [3:0]            last_sel;
    post_mode_t            mode_sel;

    always_comb begin : op_select
        shift_sel = sra_res;
        last_sel  = sra_last;
        mode_sel  = MODE_PASS;
        case (operation_i)
            RND_VSRA: begin
                mode_sel = MODE_ROUND;
            end
            VSRL, RND_VSRL: begin
                shift_sel = srl_res;
                last_sel  = srl_last;
                mode_sel  = (operation_i == RND_VSRL) ? MODE_ROUND : MODE_PASS;
            end
            VSLL, SAT_VSLL: begin
                shift_sel = sll_res;
                last_sel  = '0;
                mode_sel  = (operation_i == SAT_VSLL) ? MODE_SAT : MODE_PASS;
            end
            // Negative amount shifts right and positive amount saturates left
            VSATL_SMPR, VSATL_RNDR: begin
                if (!shift_amt_i[4]) begin
                    shift_sel = sll_res;
                    last_sel  = '0;
                    mode_sel  = MODE_SAT;
                end else if (operation_i == VSATL_RNDR) begin
                    mode_sel = MODE_ROUND;
                end
            end
            default: begin
                mode_sel = MODE_PASS;
            end
        endcase
    end : op_select

    logic [`VU_DATA_W-1:0] shift_q, out_left_q;
    logic [3:0]            last_q, sign_q;
    esize_t                len_q;
    post_mode_t            mode_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= data_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        shift_q    <= shift_sel;
        out_left_q <= sll_out;
        last_q     <= last_sel;
        sign_q     <= lane_sign;
        len_q      <= vector_length_i;
        mode_q     <= mode_sel;
    end

    // ----------------------------------------
    // Rounding and saturation in stage two
    // ----------------------------------------

    logic [`VU_DATA_W-1:0] round_res, sat_res;
    logic [3:0]            sat_hit;

    always_comb begin : post_stage
        round_res = shift_q;
        sat_res   = shift_q;
        sat_hit   = '0;
        if (len_q == ESIZE_8) begin
            for (int i = 0; i < 4; i++) begin
                round_res[8*i +: 8] = shift_q[8*i +: 8] + 8'(last_q[i]);
                // Set bits lost on the left or a lane that now reads negative
                if ((out_left_q[8*i +: 8] != '0) || shift_q[8*i+7]) begin
                    sat_res[8*i +: 8] = sign_q[i] ? 8'h80 : 8'h7F;
                    sat_hit[i]        = 1'b1;
                end
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                round_res[16*i +: 16] = shift_q[16*i +: 16] + 16'(last_q[2*i+1]);
                if ((out_left_q[16*i +: 16] != '0) || shift_q[16*i+15]) begin
                    sat_res[16*i +: 16] = sign_q[2*i+1] ? 16'h8000 : 16'h7FFF;
                    sat_hit[2*i+1]      = 1'b1;
                end
            end
        end
    end : post_stage

    // Overflow covers every lane that clamped
    always_comb begin : result_mux
        result_o        = shift_q;
        overflow_flag_o = 1'b0;
        case (mode_q)
            MODE_ROUND: result_o = round_res;
            MODE_SAT: begin
                result_o        = sat_res;
                overflow_flag_o = |sat_hit;
            end
            default: result_o = shift_q;
        endcase
    end : result_mux

    // Valid feeds the busy logic in the register block
    a_valid_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(data_valid_o)
    );

endmodule : vector_shift_unit

/* design/vector_add_unit.sv */
`timescale 1ns/1ps
`include "vector_unit_macros.svh"

module vector_add_unit import vector_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  data_valid_i,
    input  logic [`VU_DATA_W-1:0] operand_a_i,
    input  logic [`VU_DATA_W-1:0] operand_b_i,
    input  esize_t                vector_length_i,
    input  vadd_uops_t            operation_i,
    output logic [`VU_DATA_W-1:0] result_o,
    output logic                  data_valid_o,
    output logic                  overflow_flag_o
);

    // ----------------------------------------
    // Lane adders of stage one
    // ----------------------------------------

    logic                  sub_op;
    logic [`VU_DATA_W-1:0] sum_d;
    logic [3:0]            ovf_d;

    assign sub_op = (operation_i == VSUB) || (operation_i == SAT_VSUB);

    // Subtract as a + ~b + 1 with a carry in per lane
    always_comb begin : lane_add
        logic [7:0]  b8;
        logic [15:0] b16;
        sum_d = '0;
        ovf_d = '0;
        b8    = '0;
        b16   = '0;
        if (vector_length_i == ESIZE_8) begin
            for (int i = 0; i < 4; i++) begin
                b8 = sub_op ? ~operand_b_i[8*i +: 8] : operand_b_i[8*i +: 8];
                sum_d[8*i +: 8] = operand_a_i[8*i +: 8] + b8 + 8'(sub_op);
                // Same-sign inputs with a flipped result sign
                ovf_d[i] = (operand_a_i[8*i+7] == b8[7]) &&
                           (sum_d[8*i+7] != operand_a_i[8*i+7]);
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                b16 = sub_op ? ~operand_b_i[16*i +: 16] : operand_b_i[16*i +: 16];
                sum_d[16*i +: 16] = operand_a_i[16*i +: 16] + b16 + 16'(sub_op);
                ovf_d[2*i+1] = (operand_a_i[16*i+15] == b16[15]) &&
                               (sum_d[16*i+15] != operand_a_i[16*i+15]);
            end
        end
    end : lane_add

    logic [`VU_DATA_W-1:0] sum_q;
    logic [3:0]            ovf_q;
    esize_t                len_q;
    vadd_uops_t            op_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_valid_o <= 1'b0;
        end else begin
            data_valid_o <= data_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q <= sum_d;
        ovf_q <= ovf_d;
        len_q <= vector_length_i;
        op_q  <= operation_i;
    end

    // ----------------------------------------
    // Signed saturation in stage two
    // ----------------------------------------

    logic sat_op;

    assign sat_op = (op_q == SAT_VADD) || (op_q == SAT_VSUB);

    // Wrapped MSB set means the true result was positive
    always_comb begin : saturate
        result_o = sum_q;
        if (sat_op && (len_q == ESIZE_8)) begin
            for (int i = 0; i < 4; i++) begin
                if (ovf_q[i]) begin
                    result_o[8*i +: 8] = sum_q[8*i+7] ? 8'h7F : 8'h80;
                end
            end
        end else if (sat_op) begin
            for (int i = 0; i < 2; i++) begin
                if (ovf_q[2*i+1]) begin
                    result_o[16*i +: 16] = sum_q[16*i+15] ? 16'h7FFF : 16'h8000;
                end
            end
        end
    end : saturate

    assign overflow_flag_o = sat_op && (ovf_q != '0);

    // A wrapping op launched here never reports overflow when it completes
    a_wrap_no_ovf : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_i && (operation_i inside {VADD, VSUB})) |=> !overflow_flag_o
    );

endmodule : vector_add_unit

/* design/vector_wb_regs.sv */
`timescale 1ns/1ps
`include "vector_unit_macros.svh"

module vector_wb_regs import vector_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Wishbone classic slave
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`VU_ADDR_W-1:0] wb_adr_i,
    input  logic [`VU_DATA_W-1:0] wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    output logic [`VU_DATA_W-1:0] wb_dat_o,
    output logic                  wb_ack_o,
    // To the execution units
    output logic [`VU_DATA_W-1:0] operand_a_o,
    output logic [`VU_DATA_W-1:0] operand_b_o,
    output esize_t                esize_o,
    output logic                  shift_valid_o,
    output vshift_uops_t          shift_op_o,
    output logic                  add_valid_o,
    output vadd_uops_t            add_op_o,
    // From the execution units
    input  logic [`VU_DATA_W-1:0] shift_result_i,
    input  logic                  shift_valid_i,
    input  logic                  shift_overflow_i,
    input  logic [`VU_DATA_W-1:0] add_result_i,
    input  logic                  add_valid_i,
    input  logic                  add_overflow_i
);

    logic [`VU_DATA_W-1:0] opa_q, opb_q, result_q;
    vunit_op_t             ctrl_op_q;
    esize_t                ctrl_esize_q;
    logic                  busy_q, ovf_q;

    // ----------------------------------------
    // Bus acceptance
    // ----------------------------------------

    logic      stall, accept, ctrl_wr, shift_sel, add_sel;
    vunit_op_t op_in;

    // Result reads and CTRL writes wait out a running operation
    assign stall = busy_q && ((wb_we_i && (wb_adr_i == `VU_REG_CTRL)) ||
                              (!wb_we_i && (wb_adr_i == `VU_REG_RESULT)));
    assign accept  = wb_cyc_i && wb_stb_i && !wb_ack_o && !stall;
    assign ctrl_wr = accept && wb_we_i && (wb_adr_i == `VU_REG_CTRL);

    // Opcodes decode straight from write data so the units launch this cycle
    assign op_in      = vunit_op_t'(wb_dat_i[3:0]);
    assign shift_sel  = op_in inside {[OP_VSRA:OP_VSATL_RNDR]};
    assign add_sel    = op_in inside {[OP_VADD:OP_SAT_VSUB]};
    assign shift_op_o = vshift_uops_t'(wb_dat_i[2:0]);
    assign add_op_o   = vadd_uops_t'(wb_dat_i[1:0]);
    assign esize_o    = esize_t'(wb_dat_i[5:4]);

    assign shift_valid_o = ctrl_wr && shift_sel;
    assign add_valid_o   = ctrl_wr && add_sel;
    assign operand_a_o   = opa_q;
    assign operand_b_o   = opb_q;

    // ----------------------------------------
    // Registers, read data and busy
    // ----------------------------------------

    // Byte selects are ignored and every access is a full word
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o     <= 1'b0;
            wb_dat_o     <= '0;
            opa_q        <= '0;
            opb_q        <= '0;
            ctrl_op_q    <= OP_VSRA;
            ctrl_esize_q <= ESIZE_8;
            result_q     <= '0;
            busy_q       <= 1'b0;
            ovf_q        <= 1'b0;
        end else begin
            wb_ack_o <= accept;
            if (accept && wb_we_i) begin
                case (wb_adr_i)
                    `VU_REG_OPA: opa_q <= wb_dat_i;
                    `VU_REG_OPB: opb_q <= wb_dat_i;
                    `VU_REG_CTRL: begin
                        ctrl_op_q    <= op_in;
                        ctrl_esize_q <= esize_o;
                    end
                    default: ;
                endcase
            end
            if (accept && !wb_we_i) begin
                case (wb_adr_i)
                    `VU_REG_OPA:    wb_dat_o <= opa_q;
                    `VU_REG_OPB:    wb_dat_o <= opb_q;
                    `VU_REG_CTRL:   wb_dat_o <= {{(`VU_DATA_W-6){1'b0}}, ctrl_esize_q, ctrl_op_q};
                    `VU_REG_RESULT: wb_dat_o <= result_q;
                    `VU_REG_STATUS: wb_dat_o <= {{(`VU_DATA_W-2){1'b0}}, ovf_q, busy_q};
                    default:        wb_dat_o <= '0;
                endcase
            end
            // Reserved opcodes launch nothing and leave busy clear
            if (shift_valid_o || add_valid_o) begin
                busy_q <= 1'b1;
            end else if (shift_valid_i || add_valid_i) begin
                busy_q <= 1'b0;
            end
            if (shift_valid_i) begin
                result_q <= shift_result_i;
                ovf_q    <= shift_overflow_i;
            end else if (add_valid_i) begin
                result_q <= add_result_i;
                ovf_q    <= add_overflow_i;
            end
        end
    end

    // Host drops stb in the cycle after the single-cycle ack
    a_stb_after_ack : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) wb_ack_o |=> !wb_stb_i
    );

endmodule : vector_wb_regs

/* design/vector_unit_top.sv */
`timescale 1ns/1ps
`include "vector_unit_macros.svh"

module vector_unit_top import vector_unit_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`VU_ADDR_W-1:0] wb_adr_i,
    input  logic [`VU_DATA_W-1:0] wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    output logic [`VU_DATA_W-1:0] wb_dat_o,
    output logic                  wb_ack_o
);

    // Register block to units
    logic [`VU_DATA_W-1:0] operand_a, operand_b;
    esize_t                esize;
    logic                  shift_valid, add_valid;
    vshift_uops_t          shift_op;
    vadd_uops_t            add_op;

    // Units back to register block
    logic [`VU_DATA_W-1:0] shift_result, add_result;
    logic                  shift_done, add_done;
    logic                  shift_overflow, add_overflow;

    vector_wb_regs regs_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_sel_i         (wb_sel_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .operand_a_o      (operand_a),
        .operand_b_o      (operand_b),
        .esize_o          (esize),
        .shift_valid_o    (shift_valid),
        .shift_op_o       (shift_op),
        .add_valid_o      (add_valid),
        .add_op_o         (add_op),
        .shift_result_i   (shift_result),
        .shift_valid_i    (shift_done),
        .shift_overflow_i (shift_overflow),
        .add_result_i     (add_result),
        .add_valid_i      (add_done),
        .add_overflow_i   (add_overflow)
    );

    // Shift amount is the low five bits of OPB
    vector_shift_unit shift_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .data_valid_i    (shift_valid),
        .operand_i       (operand_a),
        .shift_amt_i     (operand_b[4:0]),
        .vector_length_i (esize),
        .operation_i     (shift_op),
        .result_o        (shift_result),
        .data_valid_o    (shift_done),
        .overflow_flag_o (shift_overflow)
    );

    vector_add_unit add_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .data_valid_i    (add_valid),
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .vector_length_i (esize),
        .operation_i     (add_op),
        .result_o        (add_result),
        .data_valid_o    (add_done),
        .overflow_flag_o (add_overflow)
    );

endmodule : vector_unit_top

/* tb/tb_vector_unit.sv */
`timescale 1ns/1ps
`include "vector_unit_macros.svh"

module tb_vector_unit;

    // Six hex words per test in the vector file
    localparam int MAX_VECTORS = 64;
    localparam int FIELDS      = 6;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  wb_cyc, wb_stb, wb_we;
    logic [`VU_ADDR_W-1:0] wb_adr;
    logic [`VU_DATA_W-1:0] wb_dat_w, wb_dat_r;
    logic [3:0]            wb_sel;
    logic                  wb_ack;

    logic [31:0] vec_mem [0:MAX_VECTORS*FIELDS-1];
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    int          cycle_limit = 40 * MAX_VECTORS + 100;

    // 8 ns clock period
    always #4 clk = ~clk;

    vector_unit_top dut_i (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    // ----------------------------------------
    // Wishbone host
    // ----------------------------------------

    // Ack is sampled on the falling edge away from the DUT's update edge
    task automatic wait_for_ack();
        do begin
            @(negedge clk);
        end while (!wb_ack);
    endtask

    task automatic bus_write(input logic [`VU_ADDR_W-1:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        wait_for_ack();
        // Strobe drops on the edge after ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read(input logic [`VU_ADDR_W-1:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_for_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // ----------------------------------------
    // One vector
    // ----------------------------------------

    task automatic run_vector(input int idx);
        logic [31:0] op, esize, opa, opb, exp_res, exp_ovf;
        logic [31:0] got_res, got_status, exp_status;
        bit          ok;
        op      = vec_mem[idx*FIELDS];
        esize   = vec_mem[idx*FIELDS+1];
        opa     = vec_mem[idx*FIELDS+2];
        opb     = vec_mem[idx*FIELDS+3];
        exp_res = vec_mem[idx*FIELDS+4];
        exp_ovf = vec_mem[idx*FIELDS+5];
        // Busy must be clear once RESULT has been returned
        exp_status = {30'b0, exp_ovf[0], 1'b0};
        ok         = 1'b1;
        bus_write(`VU_REG_OPA, opa);
        bus_write(`VU_REG_OPB, opb);
        bus_write(`VU_REG_CTRL, {26'b0, esize[1:0], op[3:0]});
        // RESULT read is the very next transfer after the CTRL write
        bus_read(`VU_REG_RESULT, got_res);
        bus_read(`VU_REG_STATUS, got_status);
        if (got_res !== exp_res) begin
            $display("ERR %0t: test %0d result got %08h expected %08h",
                     $time, idx, got_res, exp_res);
            ok = 1'b0;
        end
        if (got_status !== exp_status) begin
            $display("ERR %0t: test %0d status got %08h expected %08h",
                     $time, idx, got_status, exp_status);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count = pass_count + 1;
            $display("Test %0d op %0h esize %0d passed", idx, op[3:0], esize[1:0]);
        end else begin
            fail_count = fail_count + 1;
            $display("Test %0d op %0h esize %0d failed", idx, op[3:0], esize[1:0]);
        end
    endtask

    // Run limit grows with the number of vectors
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped acknowledging bus transfers",
                     cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin : run_tests
        int num_tests;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hF;
        rst_n    = 1'b0;
        // All-ones opcode word marks the end of the loaded vectors
        for (int k = 0; k < MAX_VECTORS * FIELDS; k++) begin
            vec_mem[k] = '1;
        end
        $readmemh("tb/vector_unit_vectors.txt", vec_mem);
        num_tests = 0;
        while ((num_tests < MAX_VECTORS) && (vec_mem[num_tests*FIELDS] != '1)) begin
            num_tests = num_tests + 1;
        end
        cycle_limit = 40 * num_tests + 100;
        if (num_tests == 0) begin
            $display("No test vectors were loaded from the vector file");
            fail_count = fail_count + 1;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_vector(t);
        end
        $display("Tests run %0d, passed %0d, failed %0d", num_tests, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end : run_tests

endmodule : tb_vector_unit

/* tb/vector_unit_vectors.txt */
// Columns in hex: opcode, element size, operand A, operand B, expected result, expected overflow
// Element size 0 is four 8-bit lanes, 1 is two 16-bit lanes, 3 is reserved and reads as 1
0 1 80001234 00000004 F8000123 0
0 0 807FF010 00000003 F00FFE02 0
2 1 8000FFFF 00000008 008000FF 0
2 0 80FF3C01 00000002 203F0F00 0
0 1 F0F00F0F FFFFFFFC FF0F00F0 0
0 0 8102FF7E 0000001F C001FF3F 0
2 1 12345678 00000000 12345678 0
2 0 80808080 00000009 40404040 0
3 0 7F0302FF 00000001 40020180 0
1 1 7FFF8008 00000004 0800F801 0
1 0 7F8106FD 00000002 20E002FF 0
3 1 FFFF0001 00000001 80000001 0
5 0 1020F001 00000002 407F8004 1
5 1 01230FFF 00000003 09187FF8 0
5 1 0100FFFF 00000008 7FFF8000 1
4 0 1234F10F 00000004 204010F0 0
4 1 00010003 0000000F 80008000 0
6 1 1000E000 00000002 40008000 1
6 1 80010015 0000001D F0000002 0
7 0 7F8305FE 0000001E 20E10100 0
7 0 3F40C0BF 00000001 7E7F8080 1
6 0 7F000122 00000000 7F000122 0
8 0 FF7F8001 010180FF 00800000 0
8 1 FFFF1234 00011111 00002345 0
9 0 00801005 01012005 FF7FF000 0
9 1 00008000 00010001 FFFF7FFF 0
A 0 7F804010 01FF4020 7F807F30 1
A 1 1000F000 20000FFF 3000FFFF 0
B 1 80007FFF 0001FFFF 80007FFF 1
B 0 807F05F0 7F800A10 807FFBE0 1
8 1 7FFF8000 00018000 80000000 0
2 3 80008000 00000001 40004000 0
4 0 01020304 00000001 02040608 0
A 0 01020304 7F7F7F7F 7F7F7F7F 1
0 1 89ABCDEF 00000000 89ABCDEF 0

/* project.f */
+incdir+design
design/vector_unit_pkg.sv
design/vector_shift_unit.sv
design/vector_add_unit.sv
design/vector_wb_regs.sv
design/vector_unit_top.sv
tb/tb_vector_unit.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/Vtb_vector_unit: project.f $(wildcard design/*.sv design/*.svh tb/*.sv)
	verilator --binary --timing --assert --top-module tb_vector_unit \
		-f project.f --Mdir obj_dir -o Vtb_vector_unit

run: obj_dir/Vtb_vector_unit
	@out="$$(./obj_dir/Vtb_vector_unit)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir
